// ==== common/cd_link_pkg.sv ====
package cd_link_pkg;

  // Payload and field widths
  localparam int CMD_BITS     = 96;
  localparam int DOUT_BITS    = 80;
  localparam int LEN_BITS     = 12;

  // Default byte offset where subcode data starts in a sector download
  localparam int SECTOR_BYTES = 2352;

  // Kind codes carried toward the host
  localparam logic [15:0] KIND_DATAOUT  = 16'h0001;
  localparam logic [15:0] KIND_DATA_END = 16'h0002;
  localparam logic [15:0] KIND_RESET    = 16'h00FF;

  typedef logic [7:0] cd_byte_t;

  // Message toward the host, toggle on top
  typedef struct packed {
    logic                toggle;
    logic [15:0]         kind;
    logic [CMD_BITS-1:0] payload;
  } cd_host_msg_t;

  // Reply word from the host
  typedef struct packed {
    logic        toggle;
    logic [93:0] reserved;
    logic        region;
    logic        dout_flag;
    cd_byte_t    msg;
    cd_byte_t    stat;
  } cd_drive_msg_t;

  // Latched drive status
  typedef struct packed {
    cd_byte_t msg;
    cd_byte_t stat;
  } cd_status_t;

  // First word of a download
  typedef struct packed {
    logic                dm;
    logic                cdg;
    logic [1:0]          reserved;
    logic [LEN_BITS-1:0] len;
  } cd_hdr_t;

  // Every later word, two bytes
  typedef struct packed {
    cd_byte_t hi;
    cd_byte_t lo;
  } cd_data_word_t;

  // Same 16 bits, read as header or as data
  typedef union packed {
    cd_hdr_t       hdr;
    cd_data_word_t data;
  } cd_host_word_u;

endpackage

// ==== cd_mailbox/cd_cmd_sender.sv ====
`timescale 1ns/1ps

module cd_cmd_sender (
  input  logic                              clk_sys_42_95,
  input  logic                              reset,
  input  logic                              cd_en,
  input  logic [cd_link_pkg::CMD_BITS-1:0]  comm,
  input  logic                              comm_send,
  input  logic [cd_link_pkg::DOUT_BITS-1:0] dout,
  input  logic                              dout_send,
  input  logic                              data_end,
  input  logic                              drive_reset_req,
  output cd_link_pkg::cd_host_msg_t         host_msg
);
  import cd_link_pkg::*;

  // The four request strobes, in priority order
  typedef struct packed {
    logic comm;
    logic dout;
    logic dend;
    logic rst;
  } cd_req_t;

  cd_req_t      req;
  cd_req_t      req_prev;
  cd_req_t      req_rise;
  logic         served;

  // Zero at power-up, kept through reset
  cd_host_msg_t msg_q = '0;

  assign req      = {comm_send, dout_send, data_end, drive_reset_req};
  assign req_rise = req & ~req_prev;
  assign served   = |req_rise;
  assign host_msg = msg_q;

  // Strobe history
  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      req_prev <= '0;
    end else begin
      req_prev <= req;
    end
  end

  // Build the message for the highest rise; lower ones at the same edge are dropped
  always_ff @(posedge clk_sys_42_95) begin
    if (!reset) begin
      if (req_rise.comm) begin
        msg_q.payload <= comm;
        msg_q.kind    <= {cd_en, 15'd0};
      end else if (req_rise.dout) begin
        // Upper payload bits keep the last command
        msg_q.payload[DOUT_BITS-1:0] <= dout;
        msg_q.kind                   <= KIND_DATAOUT;
      end else if (req_rise.dend) begin
        msg_q.kind <= KIND_DATA_END;
      end else if (req_rise.rst) begin
        msg_q.kind <= KIND_RESET;
      end

      // Host notices a new message by the toggle change
      if (served) begin
        msg_q.toggle <= ~msg_q.toggle;
      end
    end
  end

endmodule

// ==== cd_mailbox/cd_stat_receiver.sv ====
`timescale 1ns/1ps

module cd_stat_receiver (
  input  logic                       clk_sys_42_95,
  input  logic                       reset,
  input  cd_link_pkg::cd_drive_msg_t drive_msg,
  output cd_link_pkg::cd_status_t    status,
  output logic                       stat_get,
  output logic                       dout_req,
  output logic                       region
);
  import cd_link_pkg::*;

  logic       last_toggle;
  logic       new_reply;
  cd_status_t status_q;

  // Host posted a fresh reply
  assign new_reply = drive_msg.toggle != last_toggle;
  assign status    = status_q;

  // Status bytes, payload only
  always_ff @(posedge clk_sys_42_95) begin
    if (new_reply) begin
      status_q.msg  <= drive_msg.msg;
      status_q.stat <= drive_msg.stat;
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      last_toggle <= 1'b0;
      stat_get    <= 1'b0;
      dout_req    <= 1'b0;
      region      <= 1'b0;
    end else begin
      // Single cycle pulses
      stat_get <= 1'b0;
      dout_req <= 1'b0;
      if (new_reply) begin
        last_toggle <= drive_msg.toggle;
        // dout_flag picks which request the console sees
        stat_get    <= ~drive_msg.dout_flag;
        dout_req    <= drive_msg.dout_flag;
        region      <= drive_msg.region;
      end
    end
  end

endmodule

// ==== cd_sector/cd_sector_unpacker.sv ====
`timescale 1ns/1ps

module cd_sector_unpacker #(
  parameter int SUBCODE_OFFSET = cd_link_pkg::SECTOR_BYTES
) (
  input  logic                       clk_sys_42_95,
  input  logic                       reset,
  input  logic                       download,
  input  logic                       host_wr,
  input  cd_link_pkg::cd_host_word_u host_word,
  output cd_link_pkg::cd_byte_t      cd_data,
  output logic                       cd_wr,
  output logic                       cd_dm,
  output logic                       cd_sub
);
  import cd_link_pkg::*;

  logic                download_q;
  logic                download_rise;

  // Header state
  logic                head_seen;
  logic                cdg;
  logic [LEN_BITS-1:0] len;

  // Byte stream state
  logic [LEN_BITS-1:0] cnt;
  logic                write_active;
  logic                byte_sel;
  cd_data_word_t       hold;

  logic                hdr_accept;
  logic                word_accept;
  logic                byte_done;
  logic                last_byte;

  assign download_rise = download & ~download_q;

  // First strobe of a download is the header, the rest are data
  assign hdr_accept  = download && host_wr && !download_rise && !head_seen;
  assign word_accept = download && host_wr && !download_rise && head_seen && (cnt < len);

  // Second phase of a byte strobe
  assign byte_done = write_active & cd_wr;

  // Odd length ends after the low byte
  assign last_byte = byte_sel | (cnt >= len - 1'b1);

  // Low byte first
  assign cd_data = byte_sel ? hold.hi : hold.lo;

  // One word holding register
  always_ff @(posedge clk_sys_42_95) begin
    if (word_accept) begin
      hold <= host_word.data;
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      download_q   <= 1'b0;
      head_seen    <= 1'b0;
      cdg          <= 1'b0;
      len          <= '0;
      cnt          <= '0;
      cd_dm        <= 1'b0;
      write_active <= 1'b0;
      byte_sel     <= 1'b0;
      cd_wr        <= 1'b0;
      cd_sub       <= 1'b0;
    end else begin
      download_q <= download;

      if (hdr_accept) begin
        len       <= host_word.hdr.len;
        cd_dm     <= host_word.hdr.dm;
        cdg       <= host_word.hdr.cdg;
        cnt       <= '0;
        head_seen <= 1'b1;
      end else if (word_accept) begin
        write_active <= 1'b1;
        byte_sel     <= 1'b0;
      end

      // Strobe high one cycle, then low one cycle, per byte
      if (write_active && !cd_wr) begin
        cd_wr <= 1'b1;
      end

      if (byte_done) begin
        cd_wr    <= 1'b0;
        byte_sel <= ~byte_sel;
        cnt      <= cnt + 1'b1;
        // Bytes past the payload carry subcode; flag sticks
        if (cdg && cnt >= SUBCODE_OFFSET) begin
          cd_sub <= 1'b1;
        end
        if (last_byte) begin
          write_active <= 1'b0;
        end
      end

      // New download starts from a clean header
      if (download_rise) begin
        head_seen <= 1'b0;
        cdg       <= 1'b0;
        len       <= '0;
        cnt       <= '0;
        cd_dm     <= 1'b0;
        cd_sub    <= 1'b0;
      end
    end
  end

endmodule

// ==== design/cd_link_top.sv ====
`timescale 1ns/1ps

module cd_link_top #(
  parameter int SUBCODE_OFFSET = cd_link_pkg::SECTOR_BYTES
) (
  input  logic                                  clk_sys_42_95,
  input  logic                                  reset,

  // Console side requests
  input  logic                                  cd_en,
  input  logic [cd_link_pkg::CMD_BITS-1:0]      comm,
  input  logic                                  comm_send,
  input  logic [cd_link_pkg::DOUT_BITS-1:0]     dout,
  input  logic                                  dout_send,
  input  logic                                  data_end,
  input  logic                                  drive_reset_req,

  // Mailbox toward and from the host
  output cd_link_pkg::cd_host_msg_t             host_msg,
  input  cd_link_pkg::cd_drive_msg_t            drive_msg,

  // Drive status toward the console
  output cd_link_pkg::cd_status_t               status,
  output logic                                  stat_get,
  output logic                                  dout_req,
  output logic                                  region,

  // Sector download
  input  logic                                  download,
  input  logic                                  host_wr,
  input  cd_link_pkg::cd_host_word_u            host_word,
  output cd_link_pkg::cd_byte_t                 cd_data,
  output logic                                  cd_wr,
  output logic                                  cd_dm,
  output logic                                  cd_sub
);
  import cd_link_pkg::*;

  cd_cmd_sender u_cmd_sender (
    .clk_sys_42_95   (clk_sys_42_95),
    .reset           (reset),
    .cd_en           (cd_en),
    .comm            (comm),
    .comm_send       (comm_send),
    .dout            (dout),
    .dout_send       (dout_send),
    .data_end        (data_end),
    .drive_reset_req (drive_reset_req),
    .host_msg        (host_msg)
  );

  cd_stat_receiver u_stat_receiver (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .drive_msg     (drive_msg),
    .status        (status),
    .stat_get      (stat_get),
    .dout_req      (dout_req),
    .region        (region)
  );

  // Subcode offset set here, per product
  cd_sector_unpacker #(
    .SUBCODE_OFFSET (SUBCODE_OFFSET)
  ) u_sector_unpacker (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .download      (download),
    .host_wr       (host_wr),
    .host_word     (host_word),
    .cd_data       (cd_data),
    .cd_wr         (cd_wr),
    .cd_dm         (cd_dm),
    .cd_sub        (cd_sub)
  );

endmodule

// ==== verification/tb_cd_link.sv ====
`timescale 1ns/1ps

module tb_cd_link;
  import cd_link_pkg::*;

  localparam int SUB_OFFSET = 16;
  localparam int NUM_TESTS  = 5;
  localparam int NUM_WORDS  = 20;
  localparam int TIMEOUT_NS = NUM_TESTS * 5000 + NUM_WORDS * 20;

  logic                 clk_sys_42_95;
  logic                 reset;
  logic                 cd_en;
  logic [CMD_BITS-1:0]  comm;
  logic                 comm_send;
  logic [DOUT_BITS-1:0] dout;
  logic                 dout_send;
  logic                 data_end;
  logic                 drive_reset_req;
  cd_host_msg_t         host_msg;
  cd_drive_msg_t        drive_msg;
  cd_status_t           status;
  logic                 stat_get;
  logic                 dout_req;
  logic                 region;
  logic                 download;
  logic                 host_wr;
  cd_host_word_u        host_word;
  cd_byte_t             cd_data;
  logic                 cd_wr;
  logic                 cd_dm;
  logic                 cd_sub;

  int                   errors = 0;
  logic [31:0]          rng_state = 32'd66091;
  cd_host_msg_t         exp_msg;
  cd_byte_t             got_bytes[$];
  logic                 sub_seen[$];
  cd_byte_t             exp_bytes[$];
  int                   exp_len;

  cd_link_top #(
    .SUBCODE_OFFSET (SUB_OFFSET)
  ) u_dut (
    .clk_sys_42_95   (clk_sys_42_95),
    .reset           (reset),
    .cd_en           (cd_en),
    .comm            (comm),
    .comm_send       (comm_send),
    .dout            (dout),
    .dout_send       (dout_send),
    .data_end        (data_end),
    .drive_reset_req (drive_reset_req),
    .host_msg        (host_msg),
    .drive_msg       (drive_msg),
    .status          (status),
    .stat_get        (stat_get),
    .dout_req        (dout_req),
    .region          (region),
    .download        (download),
    .host_wr         (host_wr),
    .host_word       (host_word),
    .cd_data         (cd_data),
    .cd_wr           (cd_wr),
    .cd_dm           (cd_dm),
    .cd_sub          (cd_sub)
  );

  initial begin
    clk_sys_42_95 = 1'b0;
    forever #10 clk_sys_42_95 = ~clk_sys_42_95;
  end

  // Byte monitor samples mid-cycle while the strobe is high
  always @(negedge clk_sys_42_95) begin
    if (cd_wr === 1'b1) begin
      got_bytes.push_back(cd_data);
      sub_seen.push_back(cd_sub);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, simulation stopped", TIMEOUT_NS);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [95:0] random_96();
    logic [95:0] v;
    v[31:0]  = next_random();
    v[63:32] = next_random();
    v[95:64] = next_random();
    return v;
  endfunction

  // Inputs change 2 ns past the edge
  task automatic next_cycle();
    @(posedge clk_sys_42_95);
    #2;
  endtask

  task automatic check_host_msg(input cd_host_msg_t got, input cd_host_msg_t exp,
                                input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: host_msg %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input cd_status_t got, input cd_status_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: status %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(input cd_byte_t got, input cd_byte_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: byte %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("ERR %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // One cycle of strobes before all go low again
  task automatic pulse_strobes(input logic c, input logic d, input logic e, input logic r);
    comm_send       = c;
    dout_send       = d;
    data_end        = e;
    drive_reset_req = r;
    next_cycle();
    comm_send       = 1'b0;
    dout_send       = 1'b0;
    data_end        = 1'b0;
    drive_reset_req = 1'b0;
  endtask

  task automatic test_command();
    logic [CMD_BITS-1:0] payload;
    payload = random_96();
    exp_msg = '0;
    check_host_msg(host_msg, exp_msg, "after power-up");
    cd_en     = 1'b1;
    comm      = payload;
    comm_send = 1'b1;
    next_cycle();
    exp_msg.payload = payload;
    // Enable level sits in the top kind bit
    exp_msg.kind    = 16'h8000;
    exp_msg.toggle  = ~exp_msg.toggle;
    check_host_msg(host_msg, exp_msg, "command");
    // Held strobe must not flip again
    repeat (3) begin
      next_cycle();
      check_host_msg(host_msg, exp_msg, "command strobe held");
    end
    comm_send = 1'b0;
    next_cycle();
  endtask

  task automatic test_kinds();
    logic [95:0] r;
    r    = random_96();
    dout = r[DOUT_BITS-1:0];
    pulse_strobes(1'b0, 1'b1, 1'b0, 1'b0);
    exp_msg.payload[DOUT_BITS-1:0] = r[DOUT_BITS-1:0];
    exp_msg.kind                   = 16'h0001;
    exp_msg.toggle                 = ~exp_msg.toggle;
    check_host_msg(host_msg, exp_msg, "data-out");
    next_cycle();

    pulse_strobes(1'b0, 1'b0, 1'b1, 1'b0);
    exp_msg.kind   = 16'h0002;
    exp_msg.toggle = ~exp_msg.toggle;
    check_host_msg(host_msg, exp_msg, "data end");
    next_cycle();

    pulse_strobes(1'b0, 1'b0, 1'b0, 1'b1);
    exp_msg.kind   = 16'h00FF;
    exp_msg.toggle = ~exp_msg.toggle;
    check_host_msg(host_msg, exp_msg, "drive reset");
    next_cycle();

    // Command wins over data end at the same edge
    cd_en = 1'b0;
    comm  = random_96();
    pulse_strobes(1'b1, 1'b0, 1'b1, 1'b0);
    exp_msg.payload = comm;
    exp_msg.kind    = 16'h0000;
    exp_msg.toggle  = ~exp_msg.toggle;
    check_host_msg(host_msg, exp_msg, "command with data end");
    next_cycle();
    check_host_msg(host_msg, exp_msg, "after simultaneous rise");
  endtask

  task automatic send_reply(input logic flag, input logic region_bit, input cd_status_t st);
    int gets;
    int reqs;
    gets = 0;
    reqs = 0;
    drive_msg.toggle    = ~drive_msg.toggle;
    drive_msg.dout_flag = flag;
    drive_msg.region    = region_bit;
    drive_msg.msg       = st.msg;
    drive_msg.stat      = st.stat;
    repeat (4) begin
      next_cycle();
      if (stat_get === 1'b1) gets++;
      if (dout_req === 1'b1) reqs++;
    end
    check_count(gets, flag ? 0 : 1, "stat_get pulses");
    check_count(reqs, flag ? 1 : 0, "dout_req pulses");
    check_status(status, st, "after reply");
    check_flag(region, region_bit, "region level");
  endtask

  task automatic test_status();
    cd_status_t st;
    logic [31:0] r;
    int          pulses;
    check_flag(stat_get, 1'b0, "stat_get after reset");
    check_flag(region, 1'b0, "region after reset");
    r = next_random();
    st = r[15:0];
    send_reply(1'b0, 1'b1, st);
    r = next_random();
    st = r[15:0];
    send_reply(1'b1, 1'b0, st);
    // Same toggle with new bytes gives no pulse
    pulses         = 0;
    drive_msg.msg  = ~st.msg;
    drive_msg.stat = ~st.stat;
    repeat (4) begin
      next_cycle();
      if (stat_get === 1'b1 || dout_req === 1'b1) pulses++;
    end
    check_count(pulses, 0, "pulses without toggle change");
    check_status(status, st, "without toggle change");
  endtask

  // Rising download followed by the header word
  task automatic start_download(input logic dm, input logic cdg, input int len);
    cd_hdr_t h;
    download = 1'b0;
    next_cycle();
    download = 1'b1;
    next_cycle();
    next_cycle();
    got_bytes.delete();
    sub_seen.delete();
    exp_bytes.delete();
    exp_len       = len;
    h.dm          = dm;
    h.cdg         = cdg;
    h.reserved    = 2'b00;
    h.len         = len[LEN_BITS-1:0];
    host_word.hdr = h;
    host_wr       = 1'b1;
    next_cycle();
    host_wr = 1'b0;
    repeat (4) next_cycle();
  endtask

  // Word strobes spaced 6 cycles apart
  task automatic send_data_word();
    logic [31:0] r;
    r = next_random();
    host_word.data.lo = r[7:0];
    host_word.data.hi = r[15:8];
    if (exp_bytes.size() < exp_len) exp_bytes.push_back(r[7:0]);
    if (exp_bytes.size() < exp_len) exp_bytes.push_back(r[15:8]);
    host_wr = 1'b1;
    next_cycle();
    host_wr = 1'b0;
    repeat (5) next_cycle();
  endtask

  task automatic verify_stream(input string what);
    int waited;
    waited = 0;
    while (got_bytes.size() < exp_bytes.size() && waited < 50) begin
      next_cycle();
      waited++;
    end
    if (got_bytes.size() < exp_bytes.size()) begin
      errors++;
      $display("Byte strobes for %s did not all arrive in time", what);
    end
    check_count(got_bytes.size(), exp_bytes.size(), {what, " byte count"});
    foreach (exp_bytes[i]) begin
      if (i < got_bytes.size()) check_byte(got_bytes[i], exp_bytes[i], what);
    end
  endtask

  task automatic test_unpack_even();
    start_download(1'b1, 1'b0, 6);
    check_flag(cd_dm, 1'b1, "cd_dm from header");
    repeat (3) send_data_word();
    verify_stream("even length");
    // No strobe past the length
    send_data_word();
    check_count(got_bytes.size(), 6, "bytes after extra word");
  endtask

  task automatic test_unpack_odd_subcode();
    int sent;
    start_download(1'b0, 1'b0, 5);
    check_flag(cd_dm, 1'b0, "cd_dm from header");
    repeat (3) send_data_word();
    verify_stream("odd length");
    check_flag(cd_sub, 1'b0, "cd_sub without cdg");

    start_download(1'b0, 1'b1, 20);
    for (int k = 1; k <= 10; k++) begin
      send_data_word();
      sent = (2 * k > 20) ? 20 : 2 * k;
      check_flag(cd_sub, sent >= SUB_OFFSET + 1, "cd_sub during cdg download");
    end
    verify_stream("cdg download");
    // Flag seen during each strobe is high only once seventeen strobes are done
    foreach (sub_seen[i]) begin
      check_flag(sub_seen[i], i > SUB_OFFSET, "cd_sub at byte strobe");
    end

    // Sticky until the next download rises
    download = 1'b0;
    next_cycle();
    next_cycle();
    check_flag(cd_sub, 1'b1, "cd_sub after download falls");
    download = 1'b1;
    next_cycle();
    check_flag(cd_sub, 1'b0, "cd_sub after new download");
    download = 1'b0;
    next_cycle();
  endtask

  initial begin
    reset           = 1'b1;
    cd_en           = 1'b0;
    comm            = '0;
    comm_send       = 1'b0;
    dout            = '0;
    dout_send       = 1'b0;
    data_end        = 1'b0;
    drive_reset_req = 1'b0;
    drive_msg       = '0;
    download        = 1'b0;
    host_wr         = 1'b0;
    host_word       = '0;
    exp_msg         = '0;
    exp_len         = 0;
    repeat (5) @(posedge clk_sys_42_95);
    #2;
    reset = 1'b0;
    next_cycle();

    test_command();
    test_kinds();
    test_status();
    test_unpack_even();
    test_unpack_odd_subcode();

    repeat (4) next_cycle();
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
common/cd_link_pkg.sv
cd_mailbox/cd_cmd_sender.sv
cd_mailbox/cd_stat_receiver.sv
cd_sector/cd_sector_unpacker.sv
design/cd_link_top.sv
verification/tb_cd_link.sv
